/* Bender.yml */
package:
  name: lbuf

sources:
  # Packages first, then RTL
  - lbuf_geom_pkg.sv
  - wr_req_pkg.sv
  - lbuf_ram.sv
  - lbuf_fill_ctrl.sv
  - lbuf_drain_ctrl.sv
  - lbuf_occupancy.sv
  - lbuf_top.sv
  - target: test
    files:
      - tb_lbuf_top.sv

/* filelist.f */
lbuf_geom_pkg.sv
wr_req_pkg.sv
lbuf_ram.sv
lbuf_fill_ctrl.sv
lbuf_drain_ctrl.sv
lbuf_occupancy.sv
lbuf_top.sv
tb_lbuf_top.sv

/* lbuf_drain_ctrl.sv */
`timescale 1ns/100ps

module lbuf_drain_ctrl (
   input  logic                Clk_400,
   input  logic                rst,
   // Qualified read strobe from the top
   input  logic                consume,
   // Raw word from the data RAM
   input  wr_req_pkg::line_t   ram_data,
   // Data RAM read index, descending
   output lbuf_geom_pkg::ptr_t rptr,
   // Metadata RAM read index, ascending
   output lbuf_geom_pkg::ptr_t meta_idx,
   // One-cycle pulse, bank fully drained
   output logic                bank_release,
   // Lane-reordered output word
   output wr_req_pkg::line_t   out_data
);

   import lbuf_geom_pkg::*;
   import wr_req_pkg::*;

   logic first_word;
   logic in_bank1;
   ptr_t rptr_nxt;

   // --------------------------------------------------
   // Data pointer
   // --------------------------------------------------

   // Block is read back from its last word
   // Bank 0 runs 59 down to 0, bank 1 runs 119 down to 60
   assign rptr_nxt = (rptr == '0) ? BUF_LAST : rptr - ptr_t'(1);

   always_ff @(posedge Clk_400) begin
      if (rst) begin
         // Top of bank 0
         rptr <= BANK0_LAST;
      end else if (consume) begin
         rptr <= rptr_nxt;
      end
   end

   // Lowest entry of a bank is the last one to leave
   assign first_word = (rptr == '0) || (rptr == BANK1_FIRST);

   // Bank is free once its final word is taken
   assign bank_release = consume & first_word;

   // --------------------------------------------------
   // Metadata index
   // --------------------------------------------------

   assign in_bank1 = (rptr >= BANK1_FIRST);

   // Mirror of the data pointer inside its bank
   // Data 59..0 pairs with metadata 0..59
   // Data 119..60 pairs with metadata 60..119
   always_comb begin
      if (in_bank1) begin
         meta_idx = BANK1_FIRST + (BUF_LAST - rptr);
      end else begin
         meta_idx = BANK0_LAST - rptr;
      end
   end

   // --------------------------------------------------
   // Output data
   // --------------------------------------------------

   // YUV byte repacking on every lane
   assign out_data = yuv_reorder(ram_data);

endmodule

/* lbuf_fill_ctrl.sv */
`timescale 1ns/100ps

module lbuf_fill_ctrl (
   input  logic                Clk_400,
   input  logic                rst,
   // Qualified write strobe from the top
   input  logic                accept,
   output lbuf_geom_pkg::ptr_t wptr,
   // One-cycle pulse, a full bank is ready
   output logic                commit
);

   import lbuf_geom_pkg::*;

   logic last_word;
   ptr_t wptr_nxt;

   // --------------------------------------------------
   // Write pointer
   // --------------------------------------------------

   // Last entry of either bank
   assign last_word = (wptr == BANK0_LAST) || (wptr == BUF_LAST);

   // Step up, wrap from the end of bank 1 to bank 0
   assign wptr_nxt = (wptr == BUF_LAST) ? '0 : wptr + ptr_t'(1);

   always_ff @(posedge Clk_400) begin
      if (rst) begin
         // Partial block is dropped, start again in bank 0
         wptr <= '0;
      end else if (accept) begin
         wptr <= wptr_nxt;
      end
   end

   // --------------------------------------------------
   // Bank commit
   // --------------------------------------------------

   // Registered one cycle
   // The 60th word is in the RAM before the bank is counted
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         commit <= 1'b0;
      end else begin
         commit <= accept & last_word;
      end
   end

endmodule

/* lbuf_geom_pkg.sv */
package lbuf_geom_pkg;

   // --------------------------------------------------
   // Block and bank geometry
   // --------------------------------------------------

   // Words per bank, one block fills one bank
   localparam int BLOCK_WORDS = 60;
   // Two banks, filled and drained alternately
   localparam int NUM_BANKS   = 2;
   // Total entries across both banks
   localparam int BUF_DEPTH   = BLOCK_WORDS * NUM_BANKS;

   // Index into the whole buffer, 0 to 119
   typedef logic [6:0] ptr_t;

   // Committed bank count, 0 to NUM_BANKS
   typedef logic [1:0] bank_cnt_t;

   // --------------------------------------------------
   // Bank boundary indices
   // --------------------------------------------------

   // Last entry of bank 0
   localparam ptr_t BANK0_LAST  = ptr_t'(BLOCK_WORDS - 1);
   // First entry of bank 1
   localparam ptr_t BANK1_FIRST = ptr_t'(BLOCK_WORDS);
   // Last entry of bank 1, wrap point
   localparam ptr_t BUF_LAST    = ptr_t'(BUF_DEPTH - 1);

endpackage

/* lbuf_occupancy.sv */
`timescale 1ns/100ps

module lbuf_occupancy (
   input  logic Clk_400,
   input  logic rst,
   // From the fill side, bank filled
   input  logic commit,
   // From the drain side, bank emptied
   input  logic bank_release,
   // Room for at least one more block
   output logic in_ready,
   // At least one block ready to drain
   output logic out_valid
);

   import lbuf_geom_pkg::*;

   // Banks holding a committed, undrained block
   bank_cnt_t bank_cnt;

   // --------------------------------------------------
   // Bank counter
   // --------------------------------------------------

   always_ff @(posedge Clk_400) begin
      if (rst) begin
         bank_cnt <= '0;
      end else if (commit && !bank_release) begin
         bank_cnt <= bank_cnt + bank_cnt_t'(1);
      end else if (!commit && bank_release) begin
         bank_cnt <= bank_cnt - bank_cnt_t'(1);
      end
      // Commit and release together leave the count as it is
   end

   // --------------------------------------------------
   // Handshake flags
   // --------------------------------------------------

   // Producer stalls only with both banks full
   // A bank whose last word landed on the previous edge already counts as full
   assign in_ready = (int'(bank_cnt) + int'(commit)) < NUM_BANKS;

   // Sink sees data as soon as one bank is committed
   assign out_valid = (bank_cnt != '0);

endmodule

/* lbuf_ram.sv */
`timescale 1ns/100ps

module lbuf_ram #(
   // Payload stored per entry, data word or metadata
   parameter type payload_t = logic
) (
   input  logic                Clk_400,
   input  logic                we,
   input  lbuf_geom_pkg::ptr_t waddr,
   input  payload_t            wdata,
   input  lbuf_geom_pkg::ptr_t raddr,
   output payload_t            rdata
);

   import lbuf_geom_pkg::*;

   // Both banks in one array
   // Bank 0 at 0..59, bank 1 at 60..119
   payload_t mem [BUF_DEPTH];

   // Single write port on the clock
   always_ff @(posedge Clk_400) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Asynchronous read
   // Output follows the read index in the same cycle
   assign rdata = mem[raddr];

endmodule

/* lbuf_top.sv */
`timescale 1ns/100ps

module lbuf_top (
   input  logic                              Clk_400,
   input  logic                              rst,

   // Producer side
   input  logic                              wr_en,
   input  wr_req_pkg::line_t                 wr_data,
   input  logic [wr_req_pkg::ADDR_W-1:0]     wr_addr,
   input  logic [wr_req_pkg::TID_W-1:0]      wr_tid,
   input  logic                              wr_fence,
   input  logic [1:0]                        wr_len,
   input  logic                              wr_sop,
   output logic                              wr_ready,

   // Sink side
   output logic                              out_valid,
   output wr_req_pkg::line_t                 out_data,
   output logic [wr_req_pkg::ADDR_W-1:0]     out_addr,
   output logic [wr_req_pkg::TID_W-1:0]      out_tid,
   output logic                              out_fence,
   output logic [1:0]                        out_len,
   output logic                              out_sop,
   input  logic                              out_sent
);

   import lbuf_geom_pkg::*;
   import wr_req_pkg::*;

   logic     accept;
   logic     consume;
   logic     commit;
   logic     bank_release;
   ptr_t     wptr;
   ptr_t     rptr;
   ptr_t     meta_idx;
   line_t    ram_data;
   wr_meta_t meta_in;
   wr_meta_t meta_out;

   // --------------------------------------------------
   // Handshake strobes
   // --------------------------------------------------

   // Word taken from the producer
   assign accept  = wr_en & wr_ready;
   // Word taken by the sink, out_sent alone is ignored
   assign consume = out_valid & out_sent;

   // Metadata packed for storage
   assign meta_in = '{
      addr:  wr_addr,
      tid:   wr_tid,
      fence: wr_fence,
      len:   wr_len,
      sop:   wr_sop
   };

   // --------------------------------------------------
   // Control
   // --------------------------------------------------

   lbuf_fill_ctrl u_fill (
      .Clk_400 (Clk_400),
      .rst     (rst),
      .accept  (accept),
      .wptr    (wptr),
      .commit  (commit)
   );

   lbuf_drain_ctrl u_drain (
      .Clk_400      (Clk_400),
      .rst          (rst),
      .consume      (consume),
      .ram_data     (ram_data),
      .rptr         (rptr),
      .meta_idx     (meta_idx),
      .bank_release (bank_release),
      .out_data     (out_data)
   );

   // Drives wr_ready and out_valid directly
   lbuf_occupancy u_occ (
      .Clk_400      (Clk_400),
      .rst          (rst),
      .commit       (commit),
      .bank_release (bank_release),
      .in_ready     (wr_ready),
      .out_valid    (out_valid)
   );

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------

   // Data read in reverse order
   lbuf_ram #(.payload_t(line_t)) data_ram (
      .Clk_400 (Clk_400),
      .we      (accept),
      .waddr   (wptr),
      .wdata   (wr_data),
      .raddr   (rptr),
      .rdata   (ram_data)
   );

   // Metadata read in arrival order
   lbuf_ram #(.payload_t(wr_meta_t)) meta_ram (
      .Clk_400 (Clk_400),
      .we      (accept),
      .waddr   (wptr),
      .wdata   (meta_in),
      .raddr   (meta_idx),
      .rdata   (meta_out)
   );

   // Unpack for the sink
   assign out_addr  = meta_out.addr;
   assign out_tid   = meta_out.tid;
   assign out_fence = meta_out.fence;
   assign out_len   = meta_out.len;
   assign out_sop   = meta_out.sop;

endmodule

/* tb_lbuf_top.sv */
`timescale 1ns/100ps

module tb_lbuf_top;

   import lbuf_geom_pkg::*;
   import wr_req_pkg::*;

   // Inputs change this long after the rising edge
   localparam int DRV_DELAY  = 2;
   // Cycles without progress before a wait gives up
   localparam int WAIT_LIMIT = 400;

   logic                Clk_400;
   logic                rst;
   logic                wr_en;
   line_t               wr_data;
   logic [ADDR_W-1:0]   wr_addr;
   logic [TID_W-1:0]    wr_tid;
   logic                wr_fence;
   logic [1:0]          wr_len;
   logic                wr_sop;
   logic                wr_ready;
   logic                out_valid;
   line_t               out_data;
   logic [ADDR_W-1:0]   out_addr;
   logic [TID_W-1:0]    out_tid;
   logic                out_fence;
   logic [1:0]          out_len;
   logic                out_sop;
   logic                out_sent;

   // Scoreboard state
   line_t    in_data_q[$];
   wr_meta_t in_meta_q[$];
   wr_meta_t got_meta;
   int       out_k;
   int       pass_cnt;
   int       fail_cnt;
   logic     timed_out;
   logic [15:0] lfsr;

   lbuf_top dut0 (
      .Clk_400   (Clk_400),
      .rst       (rst),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .wr_addr   (wr_addr),
      .wr_tid    (wr_tid),
      .wr_fence  (wr_fence),
      .wr_len    (wr_len),
      .wr_sop    (wr_sop),
      .wr_ready  (wr_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_addr  (out_addr),
      .out_tid   (out_tid),
      .out_fence (out_fence),
      .out_len   (out_len),
      .out_sop   (out_sop),
      .out_sent  (out_sent)
   );

   // 40 ns period
   always #20 Clk_400 = ~Clk_400;

   // --------------------------------------------------
   // Random source
   // --------------------------------------------------

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] galois_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end else begin
         return s >> 1;
      end
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = galois_step(lfsr);
         r = {r[62:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic load_random_word();
      for (int i = 0; i < LINE_W / 64; i++) begin
         wr_data[i*64 +: 64] = rand_bits(64);
      end
      wr_addr  = ADDR_W'(rand_bits(ADDR_W));
      wr_tid   = TID_W'(rand_bits(TID_W));
      wr_fence = rand_bits(1) != 0;
      wr_len   = 2'(rand_bits(2));
      wr_sop   = rand_bits(1) != 0;
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // Output k carries input word 59-k, bytes repacked per lane
   function automatic line_t expected_data(input int k);
      line_t src;
      line_t res;
      int    sel;
      src = in_data_q[BLOCK_WORDS-1-k];
      for (int b = 0; b < LINE_W / 8; b++) begin
         // Byte 1 takes byte 3 of its lane and byte 3 takes byte 1
         case (b % 4)
            1:       sel = b + 2;
            3:       sel = b - 2;
            default: sel = b;
         endcase
         res[b*8 +: 8] = src[sel*8 +: 8];
      end
      return res;
   endfunction

   // Metadata keeps arrival order
   function automatic wr_meta_t expected_meta(input int k);
      return in_meta_q[k];
   endfunction

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s word %0d: got %h, expected %h", name, out_k, got, exp);
         fail_cnt++;
      end else begin
         pass_cnt++;
      end
   endtask

   task automatic check_meta(input string name, input wr_meta_t got, input wr_meta_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s word %0d: got %h, expected %h", name, out_k, got, exp);
         fail_cnt++;
      end else begin
         pass_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s at %0t: got %h, expected %h", name, $time, got, exp);
         fail_cnt++;
      end else begin
         pass_cnt++;
      end
   endtask

   // Samples at the falling edge, away from any input change
   always @(negedge Clk_400) begin
      if (rst) begin
         // Partial block is lost in the DUT as well
         in_data_q.delete();
         in_meta_q.delete();
         out_k = 0;
      end else begin
         if (wr_en && wr_ready) begin
            in_data_q.push_back(wr_data);
            in_meta_q.push_back(wr_meta_t'({wr_addr, wr_tid, wr_fence, wr_len, wr_sop}));
         end
         if (out_valid && out_sent) begin
            if (in_data_q.size() < BLOCK_WORDS) begin
               $display("Output word %0d left before its input block was complete", out_k);
               fail_cnt++;
            end else begin
               got_meta = {out_addr, out_tid, out_fence, out_len, out_sop};
               check_line("out_data", out_data, expected_data(out_k));
               check_meta("out_meta", got_meta, expected_meta(out_k));
            end
            out_k++;
            // Block done, drop it from the scoreboard
            if (out_k == BLOCK_WORDS) begin
               out_k = 0;
               if (in_data_q.size() >= BLOCK_WORDS) begin
                  repeat (BLOCK_WORDS) begin
                     void'(in_data_q.pop_front());
                     void'(in_meta_q.pop_front());
                  end
               end
            end
         end
      end
   end

   // --------------------------------------------------
   // Drive helpers
   // --------------------------------------------------

   task automatic next_drive_point();
      @(posedge Clk_400);
      #DRV_DELAY;
   endtask

   task automatic apply_reset();
      rst      = 1'b1;
      wr_en    = 1'b0;
      out_sent = 1'b0;
      repeat (3) next_drive_point();
      rst = 1'b0;
   endtask

   // Runs producer and sink together until both counts are reached
   task automatic run_traffic(input int n_in, input int n_out, input bit gaps, input bit stalls);
      int sent;
      int taken;
      int idle;
      sent  = 0;
      taken = 0;
      idle  = 0;
      while ((sent < n_in || taken < n_out) && !timed_out) begin
         if (sent < n_in && !(gaps && rand_bits(2) == 0)) begin
            wr_en = 1'b1;
            load_random_word();
         end else begin
            wr_en = 1'b0;
         end
         if (taken < n_out) begin
            out_sent = stalls ? (rand_bits(2) != 0) : 1'b1;
         end else begin
            out_sent = 1'b0;
         end
         // Handshake inputs are stable here, so the next edge acts on these
         if ((wr_en && wr_ready) || (out_valid && out_sent)) begin
            idle = 0;
         end else begin
            idle++;
         end
         if (wr_en && wr_ready) begin
            sent++;
         end
         if (out_valid && out_sent) begin
            taken++;
         end
         if (idle > WAIT_LIMIT) begin
            $display("Timeout: no progress with %0d of %0d words in, %0d of %0d out",
                     sent, n_in, taken, n_out);
            fail_cnt++;
            timed_out = 1'b1;
         end
         next_drive_point();
      end
      wr_en    = 1'b0;
      out_sent = 1'b0;
   endtask

   task automatic check_drained();
      if (in_data_q.size() != 0) begin
         $display("%0d input words are still waiting in the scoreboard", in_data_q.size());
         fail_cnt++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs_at_start);
      if (fail_cnt == errs_at_start) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         $display("Test %0d %s: %0d errors", num, name, fail_cnt - errs_at_start);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      int errs;
      Clk_400   = 1'b0;
      rst       = 1'b1;
      wr_en     = 1'b0;
      wr_data   = '0;
      wr_addr   = '0;
      wr_tid    = '0;
      wr_fence  = 1'b0;
      wr_len    = '0;
      wr_sop    = 1'b0;
      out_sent  = 1'b0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      out_k     = 0;
      timed_out = 1'b0;
      lfsr      = 16'd95;
      apply_reset();

      // Idle state, then a block one word short
      errs = fail_cnt;
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("wr_ready", wr_ready, 1'b1);
      run_traffic(59, 0, 0, 0);
      repeat (4) begin
         check_bit("out_valid", out_valid, 1'b0);
         next_drive_point();
      end
      report_test(1, "reset state and partial block", errs);

      // 60th word, commit one edge later, then a full drain
      errs = fail_cnt;
      run_traffic(1, 0, 0, 0);
      check_bit("out_valid", out_valid, 1'b0);
      next_drive_point();
      check_bit("out_valid", out_valid, 1'b1);
      run_traffic(0, 60, 0, 0);
      check_bit("out_valid", out_valid, 1'b0);
      check_drained();
      report_test(2, "single block drain", errs);

      // Both banks full with the sink stopped
      errs = fail_cnt;
      run_traffic(120, 0, 0, 0);
      // Next word offered right after the 120th, it has to wait
      wr_en = 1'b1;
      load_random_word();
      repeat (4) begin
         check_bit("wr_ready", wr_ready, 1'b0);
         next_drive_point();
      end
      wr_en = 1'b0;
      run_traffic(0, 60, 0, 0);
      check_bit("wr_ready", wr_ready, 1'b1);
      run_traffic(0, 60, 0, 0);
      check_bit("out_valid", out_valid, 1'b0);
      check_drained();
      report_test(3, "back-pressure on two full banks", errs);

      // Ten blocks with gaps and stalls
      errs = fail_cnt;
      run_traffic(600, 600, 1, 1);
      check_bit("out_valid", out_valid, 1'b0);
      check_drained();
      report_test(4, "random gaps and stalls", errs);

      // Reset part way into a block
      errs = fail_cnt;
      run_traffic(25, 0, 0, 0);
      apply_reset();
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("wr_ready", wr_ready, 1'b1);
      run_traffic(60, 60, 0, 0);
      check_bit("out_valid", out_valid, 1'b0);
      check_drained();
      report_test(5, "reset mid-block", errs);

      $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !timed_out) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* wr_req_pkg.sv */
package wr_req_pkg;

   // --------------------------------------------------
   // Write request widths
   // --------------------------------------------------

   // One cache line of 64 bytes
   localparam int LINE_W    = 512;
   // YUV lane, four bytes
   localparam int LANE_W    = 32;
   // Lanes per cache line
   localparam int NUM_LANES = LINE_W / LANE_W;
   // Cache-line address
   localparam int ADDR_W    = 20;
   // Transaction id
   localparam int TID_W     = 16;

   // Data word and one lane of it
   typedef logic [LINE_W-1:0] line_t;
   typedef logic [LANE_W-1:0] lane_t;

   // Write metadata, 40 bits, address in the top bits
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [TID_W-1:0]  tid;
      logic              fence;
      // Multi-line length code
      logic [1:0]        len;
      // Start of a multi-line packet
      logic              sop;
   } wr_meta_t;

   // --------------------------------------------------
   // YUV lane repacking
   // --------------------------------------------------

   // Per lane, bytes 1 and 3 swap places
   // Bytes 0 and 2 stay where they are
   function automatic line_t yuv_reorder(input line_t din);
      line_t dout;
      lane_t lane;
      dout = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
         lane = din[i*LANE_W +: LANE_W];
         // Output order Y1 V0 Y0 U0
         dout[i*LANE_W +: LANE_W] = {lane[15:8], lane[23:16], lane[31:24], lane[7:0]};
      end
      return dout;
   endfunction

endpackage
